//--- compile.f
source/event_pkg.sv
source/link_gate.sv
source/link_stat_counters.sv
source/event_start_detect.sv
source/event_ctrl_regs.sv
source/event_top.sv
verification/event_top_asserts.sv
verification/event_top_tb.sv

//--- Bender.yml
package:
  name: event_builder_front

sources:
  - files:
      - source/event_pkg.sv
      - source/link_gate.sv
      - source/link_stat_counters.sv
      - source/event_start_detect.sv
      - source/event_ctrl_regs.sv
      - source/event_top.sv
  - target: simulation
    files:
      - verification/event_top_asserts.sv
      - verification/event_top_tb.sv

//--- verification/event_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module event_top_tb;

    import event_pkg::*;

    localparam int COUNT_W = 32;
    localparam int TIMEOUT = 64;

    logic                       aclk;
    logic                       rst_n_i;
    logic                       event_open_i;
    logic [NUM_LINKS-1:0]       s_link_valid_i;
    link_beat_t [NUM_LINKS-1:0] s_link_beat_i;
    logic [NUM_LINKS-1:0]       s_link_ready_o;
    logic [NUM_LINKS-1:0]       m_link_valid_o;
    link_beat_t [NUM_LINKS-1:0] m_link_beat_o;
    logic [NUM_LINKS-1:0]       m_link_ready_i;
    logic                       reg_strobe_i;
    reg_req_t                   reg_req_i;
    logic [REG_DATA_W-1:0]      reg_rdata_o;
    logic                       reg_rvalid_o;
    logic                       event_start_o;

    logic [31:0] rng_state = 32'd29553;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          errors_before = 0;
    int          exp_count [NUM_LINKS];
    link_beat_t  exp_beats [NUM_LINKS][$];
    logic        track_beats = 1'b0;

    event_top #(.COUNT_W(COUNT_W)) event_top_i (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    //////////////////////////////////////////////////
    // random numbers and reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] rand_word();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // upper lcg bits are the better ones
    function automatic int unsigned rand_below(int unsigned limit);
        return (rand_word() >> 16) % limit;
    endfunction

    // only the lowest link with a clear mask bit starts an event
    function automatic logic expect_start(link_mask_t mask, int link);
        for (int i = 0; i < link; i++) begin
            if (!mask[i]) begin
                return 1'b0;
            end
        end
        return !mask[link];
    endfunction

    function automatic logic [REG_DATA_W-1:0] expect_ctrl_word(logic rst, link_mask_t mask);
        logic [REG_DATA_W-1:0] word;
        word = '0;
        word[0] = rst;
        word[11:8] = mask;
        return word;
    endfunction

    //////////////////////////////////////////////////
    // checks and reporting
    //////////////////////////////////////////////////

    task automatic note_failure(string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic check_beat(string name, link_beat_t exp, link_beat_t act);
        checks++;
        if (act !== exp) begin
            note_failure($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(string name, logic [REG_DATA_W-1:0] exp,
                              logic [REG_DATA_W-1:0] act);
        checks++;
        if (act !== exp) begin
            note_failure($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_start(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            note_failure($sformatf("error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic end_test(string name);
        tests++;
        if (errors == errors_before) begin
            $display("test %-14s pass", name);
        end else begin
            failed_tests++;
            $display("test %-14s FAIL with %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    // downstream side, compares each handshake against the queued input beats
    always @(negedge aclk) begin
        #1;
        for (int i = 0; i < NUM_LINKS; i++) begin
            if (m_link_valid_o[i] && m_link_ready_i[i]) begin
                if (track_beats && exp_beats[i].size() == 0) begin
                    note_failure($sformatf("link %0d delivered a beat nobody sent", i));
                end else if (track_beats) begin
                    check_beat($sformatf("beat link %0d", i), exp_beats[i].pop_front(),
                               m_link_beat_o[i]);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////

    task automatic reg_write(logic [REG_ADDR_W-1:0] addr, logic [REG_SEL_W-1:0] sel,
                             logic [REG_DATA_W-1:0] wdata);
        @(negedge aclk);
        reg_strobe_i = 1'b1;
        reg_req_i = '{addr: addr, we: 1'b1, sel: sel, wdata: wdata};
        @(negedge aclk);
        reg_strobe_i = 1'b0;
    endtask

    task automatic check_reg(string name, logic [REG_ADDR_W-1:0] addr,
                             logic [REG_DATA_W-1:0] exp);
        int waited;
        @(negedge aclk);
        reg_strobe_i = 1'b1;
        reg_req_i = '{addr: addr, we: 1'b0, sel: '0, wdata: '0};
        @(negedge aclk);
        reg_strobe_i = 1'b0;
        for (waited = 0; waited < TIMEOUT && !reg_rvalid_o; waited++) begin
            @(negedge aclk);
        end
        if (reg_rvalid_o) begin
            check_word(name, exp, reg_rdata_o);
        end else begin
            note_failure($sformatf("no read response for %s", name));
        end
    endtask

    task automatic check_counts(string name, logic held_zero);
        logic [REG_ADDR_W-1:0] addr;
        for (int i = 0; i < NUM_LINKS; i++) begin
            // random choice between the lower and the upper alias
            addr = REG_ADDR_W'(REG_COUNT_BASE + i + 8 * rand_below(2));
            check_reg($sformatf("%s count %0d", name, i), addr,
                      held_zero ? '0 : REG_DATA_W'(exp_count[i]));
        end
    endtask

    task automatic run_traffic(int cycles, logic [NUM_LINKS-1:0] ready, logic closed);
        for (int c = 0; c < cycles; c++) begin
            @(negedge aclk);
            for (int i = 0; i < NUM_LINKS; i++) begin
                s_link_beat_i[i] = '{data: rand_word(), last: 1'b0};
            end
            s_link_valid_i = '1;
            m_link_ready_i = ready;
            #1;
            if (closed && (s_link_ready_o !== '1 || m_link_valid_o !== '0)) begin
                note_failure("closed gate stalled a link or passed a beat downstream");
            end
        end
        @(negedge aclk);
        s_link_valid_i = '0;
    endtask

    task automatic open_event();
        int waited;
        @(negedge aclk);
        event_open_i = 1'b1;
        m_link_ready_i = '0;
        for (waited = 0; waited < TIMEOUT && s_link_ready_o != '0; waited++) begin
            @(negedge aclk);
        end
        if (s_link_ready_o != '0) begin
            note_failure("gate never opened after event_open_i rose");
        end
    endtask

    task automatic send_last(link_mask_t mask, int link);
        int   pulses;
        logic on_time;
        pulses = 0;
        on_time = 1'b0;
        @(negedge aclk);
        s_link_beat_i[link] = '{data: rand_word(), last: 1'b1};
        s_link_valid_i = '0;
        s_link_valid_i[link] = 1'b1;
        m_link_ready_i = '1;
        // two register stages, so the strobe shows in the second sample after the handshake
        for (int k = 1; k <= 5; k++) begin
            @(negedge aclk);
            s_link_valid_i = '0;
            #1;
            if (event_start_o) begin
                pulses++;
                on_time = on_time | (k == 2);
            end
        end
        check_start($sformatf("start mask %b link %0d", mask, link),
                    expect_start(mask, link), on_time);
        if (pulses > int'(on_time)) begin
            note_failure("event start strobe appeared on the wrong cycle");
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        int                   want [NUM_LINKS];
        int                   sent [NUM_LINKS];
        int                   remaining;
        int                   cyc;
        int                   traffic_len;
        logic [NUM_LINKS-1:0] ready_mask;
        logic [NUM_LINKS-1:0] accepted;
        link_beat_t           beat;
        link_mask_t           mask;
        link_mask_t           start_masks [5];

        rst_n_i = 1'b0;
        event_open_i = 1'b0;
        s_link_valid_i = '0;
        s_link_beat_i = '0;
        m_link_ready_i = '0;
        reg_strobe_i = 1'b0;
        reg_req_i = '0;
        for (int i = 0; i < NUM_LINKS; i++) begin
            exp_count[i] = 0;
        end
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        rst_n_i = 1'b1;

        mask = link_mask_t'(rand_below(16));
        reg_write(4'd0, 4'b0011, expect_ctrl_word(1'b1, mask));
        for (int a = 0; a <= REG_CTRL_LAST; a++) begin
            check_reg("ctrl alias low", 4'(a), expect_ctrl_word(1'b1, mask));
            check_reg("ctrl alias high", 4'(a + 8), expect_ctrl_word(1'b1, mask));
        end
        mask = ~mask;
        reg_write(4'd2, 4'b0010, expect_ctrl_word(1'b0, mask));
        check_reg("ctrl mask lane only", 4'd10, expect_ctrl_word(1'b1, mask));
        reg_write(4'd1, 4'b0001, expect_ctrl_word(1'b0, ~mask));
        check_reg("ctrl reset lane only", 4'd0, expect_ctrl_word(1'b0, mask));
        end_test("registers");

        run_traffic(8, '0, 1'b1);
        check_counts("closed", 1'b1);
        end_test("closed event");

        open_event();
        remaining = 0;
        for (int i = 0; i < NUM_LINKS; i++) begin
            sent[i] = 0;
            want[i] = 3 + rand_below(8);
            remaining += want[i];
        end
        accepted = '0;
        track_beats = 1'b1;
        for (cyc = 0; cyc < 400 && remaining > 0; cyc++) begin
            @(negedge aclk);
            for (int i = 0; i < NUM_LINKS; i++) begin
                if (accepted[i]) begin
                    s_link_valid_i[i] = 1'b0;
                end
                if (!s_link_valid_i[i] && sent[i] < want[i]) begin
                    beat = '{data: rand_word(), last: 1'b0};
                    s_link_beat_i[i] = beat;
                    s_link_valid_i[i] = 1'b1;
                    exp_beats[i].push_back(beat);
                end
            end
            m_link_ready_i = NUM_LINKS'(rand_below(16));
            #1;
            accepted = s_link_valid_i & s_link_ready_o;
            for (int i = 0; i < NUM_LINKS; i++) begin
                sent[i] += int'(accepted[i]);
                remaining -= int'(accepted[i]);
            end
        end
        @(negedge aclk);
        s_link_valid_i = '0;
        track_beats = 1'b0;
        if (remaining > 0) begin
            note_failure("open event traffic was still stalled at its timeout");
        end
        for (int i = 0; i < NUM_LINKS; i++) begin
            // every beat offered while open is handed downstream exactly once
            exp_count[i] = want[i];
            if (exp_beats[i].size() != 0) begin
                note_failure($sformatf("link %0d lost beats on the way downstream", i));
            end
        end
        check_counts("open", 1'b0);
        end_test("open event");

        start_masks = '{4'b0000, 4'b0001, 4'b0110, 4'b1011, 4'b1111};
        foreach (start_masks[m]) begin
            reg_write(4'd0, 4'b0010, expect_ctrl_word(1'b0, start_masks[m]));
            for (int l = 0; l < NUM_LINKS; l++) begin
                send_last(start_masks[m], l);
            end
        end
        end_test("start strobe");

        reg_write(4'd0, 4'b0001, expect_ctrl_word(1'b1, '0));
        run_traffic(6, '1, 1'b0);
        check_counts("reset held", 1'b1);
        reg_write(4'd0, 4'b0001, expect_ctrl_word(1'b0, '0));
        traffic_len = 3 + rand_below(6);
        ready_mask = NUM_LINKS'(rand_below(16));
        // a beat is offered every cycle, so a ready link takes one per cycle
        for (int i = 0; i < NUM_LINKS; i++) begin
            exp_count[i] = ready_mask[i] ? traffic_len : 0;
        end
        run_traffic(traffic_len, ready_mask, 1'b0);
        check_counts("after reset", 1'b0);
        end_test("soft reset");

        if (event_top_i.u_asserts.assert_fails != 0) begin
            note_failure("bound assertions reported violations");
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/event_top_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module event_top_asserts (
    input  logic                            aclk,
    input  logic                            rst_n_i,
    input  logic                            event_open_i,
    input  logic [event_pkg::NUM_LINKS-1:0] m_valid_i,
    input  logic [event_pkg::NUM_LINKS-1:0] s_ready_i,
    input  logic                            rd_strobe_i,
    input  logic                            rvalid_i,
    input  logic                            event_start_i
);

    import event_pkg::*;

    int unsigned assert_fails = 0;

    // a closed gate swallows everything
    // the gate sees event_open_i two edges late through the synchronizer
    closed_gate_quiet: assert property (@(posedge aclk) disable iff (!rst_n_i)
        !$past(event_open_i, 2) |-> (m_valid_i == '0 && s_ready_i == '1))
    else begin
        $error("closed gate raised m_valid or dropped s_ready");
        assert_fails++;
    end

    read_gets_rvalid: assert property (@(posedge aclk) disable iff (!rst_n_i)
        rd_strobe_i |=> rvalid_i)
    else begin
        $error("read strobe without rvalid on the next cycle");
        assert_fails++;
    end

    rvalid_only_after_read: assert property (@(posedge aclk) disable iff (!rst_n_i)
        rvalid_i |-> $past(rd_strobe_i))
    else begin
        $error("rvalid without a read strobe one cycle earlier");
        assert_fails++;
    end

    start_single_cycle: assert property (@(posedge aclk) disable iff (!rst_n_i)
        event_start_i |=> !event_start_i)
    else begin
        $error("event start strobe held for two cycles");
        assert_fails++;
    end

endmodule

bind event_top event_top_asserts u_asserts (
    .aclk          (aclk),
    .rst_n_i       (rst_n_i),
    .event_open_i  (event_open_i),
    .m_valid_i     (m_link_valid_o),
    .s_ready_i     (s_link_ready_o),
    .rd_strobe_i   (reg_strobe_i && !reg_req_i.we),
    .rvalid_i      (reg_rvalid_o),
    .event_start_i (event_start_o)
);

`default_nettype wire

//--- source/event_top.sv
`timescale 1ns/10ps
`default_nettype none

module event_top #(
    parameter int COUNT_W = 32
) (
    input  logic                                             aclk,
    input  logic                                             rst_n_i,
    input  logic                                             event_open_i,

    // incoming links
    input  logic [event_pkg::NUM_LINKS-1:0]                  s_link_valid_i,
    input  event_pkg::link_beat_t [event_pkg::NUM_LINKS-1:0] s_link_beat_i,
    output logic [event_pkg::NUM_LINKS-1:0]                  s_link_ready_o,

    // links toward the downstream builder
    output logic [event_pkg::NUM_LINKS-1:0]                  m_link_valid_o,
    output event_pkg::link_beat_t [event_pkg::NUM_LINKS-1:0] m_link_beat_o,
    input  logic [event_pkg::NUM_LINKS-1:0]                  m_link_ready_i,

    // register strobe path
    input  logic                                             reg_strobe_i,
    input  event_pkg::reg_req_t                              reg_req_i,
    output logic [event_pkg::REG_DATA_W-1:0]                 reg_rdata_o,
    output logic                                             reg_rvalid_o,

    output logic                                             event_start_o
);

    import event_pkg::*;

    ctrl_reg_t                          ctrl;
    logic [NUM_LINKS-1:0][COUNT_W-1:0]  link_count;
    logic [NUM_LINKS-1:0]               beat_xfer;
    logic [NUM_LINKS-1:0]               last_xfer;

    //////////////////////////////////////////////////
    // link gating
    //////////////////////////////////////////////////

    link_gate u_gate (
        .aclk         (aclk),
        .rst_n_i      (rst_n_i),
        .event_open_i (event_open_i),
        .s_valid_i    (s_link_valid_i),
        .s_beat_i     (s_link_beat_i),
        .s_ready_o    (s_link_ready_o),
        .m_valid_o    (m_link_valid_o),
        .m_beat_o     (m_link_beat_o),
        .m_ready_i    (m_link_ready_i)
    );

    // downstream handshakes, and the ones that close a link's event
    assign beat_xfer = m_link_valid_o & m_link_ready_i;

    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_last
        assign last_xfer[i] = beat_xfer[i] & m_link_beat_o[i].last;
    end

    //////////////////////////////////////////////////
    // statistics and event start
    //////////////////////////////////////////////////

    link_stat_counters #(
        .COUNT_W (COUNT_W)
    ) u_stats (
        .aclk         (aclk),
        .rst_n_i      (rst_n_i),
        .soft_clear_i (ctrl.event_reset),
        .beat_xfer_i  (beat_xfer),
        .count_o      (link_count)
    );

    event_start_detect u_start (
        .aclk          (aclk),
        .rst_n_i       (rst_n_i),
        .soft_clear_i  (ctrl.event_reset),
        .last_xfer_i   (last_xfer),
        .mask_i        (ctrl.mask),
        .event_start_o (event_start_o)
    );

    //////////////////////////////////////////////////
    // register block
    //////////////////////////////////////////////////

    event_ctrl_regs #(
        .COUNT_W (COUNT_W)
    ) u_regs (
        .aclk         (aclk),
        .rst_n_i      (rst_n_i),
        .reg_strobe_i (reg_strobe_i),
        .reg_req_i    (reg_req_i),
        .count_i      (link_count),
        .reg_rdata_o  (reg_rdata_o),
        .reg_rvalid_o (reg_rvalid_o),
        .ctrl_o       (ctrl)
    );

endmodule

`default_nettype wire

//--- source/event_ctrl_regs.sv
`timescale 1ns/10ps
`default_nettype none

module event_ctrl_regs #(
    parameter int COUNT_W = 32
) (
    input  logic                                         aclk,
    input  logic                                         rst_n_i,
    input  logic                                         reg_strobe_i,
    input  event_pkg::reg_req_t                          reg_req_i,
    input  logic [event_pkg::NUM_LINKS-1:0][COUNT_W-1:0] count_i,
    output logic [event_pkg::REG_DATA_W-1:0]             reg_rdata_o,
    output logic                                         reg_rvalid_o,
    output event_pkg::ctrl_reg_t                         ctrl_o
);

    import event_pkg::*;

    ctrl_reg_t               ctrl_q;
    logic                    wr_en;
    logic                    rd_en;
    logic [REG_ALIAS_BIT-1:0] word_addr;
    logic [LINK_IDX_W-1:0]   link_sel;
    logic [REG_DATA_W-1:0]   ctrl_word;
    logic [REG_DATA_W-1:0]   rd_word;
    logic [REG_DATA_W-1:0]   rdata_q;
    logic                    rvalid_q;

    assign wr_en = reg_strobe_i && reg_req_i.we;
    assign rd_en = reg_strobe_i && !reg_req_i.we;

    //////////////////////////////////////////////////
    // control register
    //////////////////////////////////////////////////

    // any address takes a write, byte lanes pick the field
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            ctrl_q <= CTRL_RESET_VALUE;
        end else if (wr_en) begin
            if (reg_req_i.sel[CTRL_RESET_BIT/8]) begin
                ctrl_q.event_reset <= reg_req_i.wdata[CTRL_RESET_BIT];
            end
            if (reg_req_i.sel[CTRL_MASK_LSB/8]) begin
                ctrl_q.mask <= reg_req_i.wdata[CTRL_MASK_LSB +: NUM_LINKS];
            end
        end
    end

    assign ctrl_o = ctrl_q;

    //////////////////////////////////////////////////
    // readback
    //////////////////////////////////////////////////

    // top address bit dropped here, this is what makes the alias
    assign word_addr = reg_req_i.addr[REG_ALIAS_BIT-1:0];
    assign link_sel  = LINK_IDX_W'(word_addr - REG_COUNT_BASE);

    always_comb begin
        ctrl_word = '0;
        ctrl_word[CTRL_RESET_BIT] = ctrl_q.event_reset;
        ctrl_word[CTRL_MASK_LSB +: NUM_LINKS] = ctrl_q.mask;
    end

    // counters are zero-extended to the full word
    always_comb begin
        rd_word = '0;
        if (word_addr <= REG_CTRL_LAST) begin
            rd_word = ctrl_word;
        end else begin
            rd_word[COUNT_W-1:0] = count_i[link_sel];
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rdata_q <= rd_word;
        end
    end

    // rvalid one cycle after a read strobe, never for writes
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_en;
        end
    end

    assign reg_rdata_o  = rdata_q;
    assign reg_rvalid_o = rvalid_q;

endmodule

`default_nettype wire

//--- source/event_start_detect.sv
`timescale 1ns/10ps
`default_nettype none

module event_start_detect (
    input  logic                            aclk,
    input  logic                            rst_n_i,
    input  logic                            soft_clear_i,
    input  logic [event_pkg::NUM_LINKS-1:0] last_xfer_i,
    input  event_pkg::link_mask_t           mask_i,
    output logic                            event_start_o
);

    import event_pkg::*;

    logic [NUM_LINKS-1:0] last_q;
    logic                 start_sel;
    logic                 start_q;

    //////////////////////////////////////////////////
    // first stage, capture last-beat handshakes
    //////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!rst_n_i || soft_clear_i) begin
            last_q <= '0;
        end else begin
            last_q <= last_xfer_i;
        end
    end

    // lowest unmasked link wins
    // walking down from the top lets the lowest index overwrite the rest
    always_comb begin
        start_sel = 1'b0;
        for (int i = NUM_LINKS - 1; i >= 0; i--) begin
            if (!mask_i[i]) begin
                start_sel = last_q[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // second stage, the strobe itself
    //////////////////////////////////////////////////

    // all links masked leaves start_sel at zero, so no strobe
    always_ff @(posedge aclk) begin
        if (!rst_n_i || soft_clear_i) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start_sel;
        end
    end

    assign event_start_o = start_q;

endmodule

`default_nettype wire

//--- source/link_stat_counters.sv
`timescale 1ns/10ps
`default_nettype none

module link_stat_counters #(
    parameter int COUNT_W = 32
) (
    input  logic                                              aclk,
    input  logic                                              rst_n_i,
    input  logic                                              soft_clear_i,
    input  logic [event_pkg::NUM_LINKS-1:0]                   beat_xfer_i,
    output logic [event_pkg::NUM_LINKS-1:0][COUNT_W-1:0]      count_o
);

    import event_pkg::*;

    logic [NUM_LINKS-1:0][COUNT_W-1:0] count_q;

    //////////////////////////////////////////////////
    // beat counters
    //////////////////////////////////////////////////

    // soft clear holds every counter at zero for as long as it is set
    always_ff @(posedge aclk) begin
        if (!rst_n_i || soft_clear_i) begin
            count_q <= '0;
        end else begin
            for (int i = 0; i < NUM_LINKS; i++) begin
                // one count per downstream handshake, wraps at the top
                if (beat_xfer_i[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end
            end
        end
    end

    assign count_o = count_q;

endmodule

`default_nettype wire

//--- source/link_gate.sv
`timescale 1ns/10ps
`default_nettype none

module link_gate (
    input  logic                                            aclk,
    input  logic                                            rst_n_i,
    input  logic                                            event_open_i,
    input  logic [event_pkg::NUM_LINKS-1:0]                 s_valid_i,
    input  event_pkg::link_beat_t [event_pkg::NUM_LINKS-1:0] s_beat_i,
    output logic [event_pkg::NUM_LINKS-1:0]                 s_ready_o,
    output logic [event_pkg::NUM_LINKS-1:0]                 m_valid_o,
    output event_pkg::link_beat_t [event_pkg::NUM_LINKS-1:0] m_beat_o,
    input  logic [event_pkg::NUM_LINKS-1:0]                 m_ready_i
);

    import event_pkg::*;

    // stage 0 catches the async input, stage 1 is the usable flag
    logic [1:0] open_sync_q;
    logic       event_open;

    //////////////////////////////////////////////////
    // event-open synchronizer
    //////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            open_sync_q <= 2'b00;
        end else begin
            open_sync_q <= {open_sync_q[0], event_open_i};
        end
    end

    assign event_open = open_sync_q[1];

    //////////////////////////////////////////////////
    // per-link gating
    //////////////////////////////////////////////////

    // open: straight through, downstream back-pressure reaches the link
    // closed: nothing goes out and every beat is swallowed
    assign m_valid_o = s_valid_i & {NUM_LINKS{event_open}};
    assign s_ready_o = m_ready_i | {NUM_LINKS{~event_open}};

    // data and last are only meaningful while m_valid_o is high
    assign m_beat_o  = s_beat_i;

endmodule

`default_nettype wire

//--- source/event_pkg.sv
`default_nettype none

package event_pkg;

    //////////////////////////////////////////////////
    // link geometry
    //////////////////////////////////////////////////

    // the register map and the mask width both assume four links
    localparam int NUM_LINKS   = 4;
    localparam int LINK_IDX_W  = $clog2(NUM_LINKS);
    localparam int LINK_DATA_W = 32;

    // one bit per link, a set bit drops that link out of start detection
    typedef logic [NUM_LINKS-1:0] link_mask_t;

    // one beat as it travels on a link
    typedef struct packed {
        logic [LINK_DATA_W-1:0] data;
        logic                   last;
    } link_beat_t;

    //////////////////////////////////////////////////
    // register interface
    //////////////////////////////////////////////////

    localparam int REG_ADDR_W = 4;
    localparam int REG_DATA_W = 32;
    localparam int REG_SEL_W  = REG_DATA_W / 8;

    // single-cycle request, qualified by a separate strobe
    typedef struct packed {
        logic [REG_ADDR_W-1:0] addr;
        logic                  we;
        logic [REG_SEL_W-1:0]  sel;
        logic [REG_DATA_W-1:0] wdata;
    } reg_req_t;

    // control state held by the register block
    typedef struct packed {
        logic       event_reset;
        link_mask_t mask;
    } ctrl_reg_t;

    localparam ctrl_reg_t CTRL_RESET_VALUE = '{event_reset: 1'b0, mask: '0};

    //////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////

    // control word layout, event_reset in byte 0 and the mask in byte 1
    localparam int CTRL_RESET_BIT = 0;
    localparam int CTRL_MASK_LSB  = 8;

    // word addresses 0..3 all return the control word
    localparam int REG_CTRL_LAST  = 3;

    // counters of links 0..3 live at 4..7
    localparam int REG_COUNT_BASE = 4;

    // address bits at and above this one are not decoded,
    // so the upper half of the map aliases the lower half
    localparam int REG_ALIAS_BIT  = 3;

endpackage

`default_nettype wire
